//--- tb/soc_input.txt
# test op addr be wdata exp_rdata exp_err, all hex except test and exp_err
# R/M read, B block read, W/V write, S mtime read, I/T irq level, D wait, G debug level
1 G 00000000 0 0000000a 00000000 0
1 G 00000000 0 00000019 00000001 0
2 B 00000000 f 00000010 b0070000 0
2 W 00000014 f 12345678 00000000 0
2 R 00000014 f 00000000 b0070005 0
3 W 00001000 f 11223344 00000000 0
3 V 00001004 f 00000000 00000000 0
3 W 00001008 f a5a5a5a5 00000000 0
3 W 00001000 5 ffeeddcc 00000000 0
3 V 00001004 a 00000000 00000000 0
3 V 00001008 2 00000000 00000000 0
3 M 00001000 f 00000000 00000000 0
3 M 00001004 f 00000000 00000000 0
3 M 00001008 f 00000000 00000000 0
3 V 000010fc f 00000000 00000000 0
3 M 000010fc f 00000000 00000000 0
4 R 01000000 f 00000000 00000000 1
4 W 00000100 f deadbeef 00000000 1
5 W 02000000 1 00000001 00000000 0
5 I 00000000 0 00000000 00000001 0
5 R 02000000 f 00000000 00000001 0
5 W 02000000 1 00000000 00000000 0
5 I 00000000 0 00000000 00000000 0
6 S 02000008 f 00000000 00000000 0
6 D 00000000 0 00000032 00000000 0
6 S 02000008 f 00000000 00000000 0
7 W 02000004 f 00000000 00000000 0
7 T 00000000 0 00000000 00000001 0
7 W 02000004 f ffffffff 00000000 0
7 T 00000000 0 00000000 00000000 0

//--- soc_subsystem.f
logic/soc_pkg.sv
logic/mem_bus_if.sv
logic/addr_decoder.sv
logic/boot_rom.sv
logic/scratchpad_ram.sv
logic/clint_timer.sv
logic/debug_gate.sv
logic/resp_mux.sv
logic/soc_subsystem.sv
tb/tb_soc_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
TOP       ?= tb_soc_subsystem
FILELIST  ?= soc_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_soc_subsystem.sv
// -------------------------------------
// Testbench for the SoC bus subsystem,
// file driven accesses with checks
// -------------------------------------
`timescale 1ns/10ps

module tb_soc_subsystem import soc_pkg::*; ();

  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned RtcPeriod   = 400;
  localparam int unsigned ResetCycles = 16;
  // Drive cycle to response cycle
  localparam int unsigned Latency     = 2;
  localparam string       InputFile   = "tb/soc_input.txt";

  typedef struct packed {
    logic [31:0] test;
    logic [31:0] due;
    data_t       data;
    logic        err;
    logic        mtime;
  } resp_t;

  logic  clk_i;
  logic  ndmreset_n;
  logic  rtc_i;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  be_t   be_i;
  data_t wdata_i;
  logic  debug_req_i;
  logic  rvalid_o;
  data_t rdata_o;
  logic  err_o;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  debug_req_o;

  resp_t exp_q [$];
  resp_t cur;
  data_t ram_model [RamWords];
  data_t last_mtime;
  logic  have_mtime;
  int    seed;
  int    cyc = 0;
  int    rel_cyc;
  int    n_lines;
  int    n_tests;
  int    test_checks;
  int    test_errs;
  int    total_checks;
  int    total_errs;

  soc_subsystem i_soc_subsystem (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .debug_req_i ( debug_req_i ),
    .rvalid_o    ( rvalid_o    ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;
  always #(RtcPeriod / 2) rtc_i = ~rtc_i;
  always @(posedge clk_i) cyc <= cyc + 1;

  // -------------------------------------
  // Reference model helpers
  // -------------------------------------
  function automatic data_t merge_lanes(data_t old_w, data_t new_w, be_t be);
    data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic is_ram(addr_t a);
    return (a >= RamBase) && (a < RamBase + RamLength);
  endfunction

  function automatic int ram_index(addr_t a);
    return int'((a - RamBase) >> 2);
  endfunction

  // -------------------------------------
  // Bus driving
  // -------------------------------------
  task automatic access(logic we, addr_t addr, be_t be, data_t wdata);
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
  endtask

  task automatic idle_bus();
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic expect_resp(int test, data_t data, logic err, logic mtime);
    resp_t e;
    e.test  = test;
    e.due   = cyc + Latency;
    e.data  = data;
    e.err   = err;
    e.mtime = mtime;
    exp_q.push_back(e);
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic check_level(string what, logic got, logic exp);
    test_checks++;
    assert (got === exp) else begin
      $display("ERR @%0t: %s expected %b got %b", $time, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic finish_test(int test);
    if (req_i) idle_bus();
    drain();
    $display("test %0d done: %0d checks, %0d errors", test, test_checks, test_errs);
    n_tests++;
    total_checks += test_checks;
    total_errs   += test_errs;
    test_checks  = 0;
    test_errs    = 0;
  endtask

  task automatic run_op(int test, logic [7:0] op, addr_t addr, be_t be, data_t wdata,
                        data_t exp_data, logic exp_err);
    data_t wd;
    case (op)
      "R": begin
        access(1'b0, addr, be, '0);
        expect_resp(test, exp_data, exp_err, 1'b0);
      end
      // Block read, word i holds exp_data plus i
      "B": begin
        for (int i = 0; i < int'(wdata); i++) begin
          access(1'b0, addr + addr_t'(4 * i), be, '0);
          expect_resp(test, exp_data + data_t'(i), 1'b0, 1'b0);
        end
      end
      "M": begin
        access(1'b0, addr, be, '0);
        expect_resp(test, ram_model[ram_index(addr)], 1'b0, 1'b0);
      end
      "W", "V": begin
        wd = (op == "V") ? $random(seed) : wdata;
        access(1'b1, addr, be, wd);
        if (is_ram(addr)) begin
          ram_model[ram_index(addr)] = merge_lanes(ram_model[ram_index(addr)], wd, be);
        end
        expect_resp(test, '0, exp_err, 1'b0);
      end
      "S": begin
        access(1'b0, addr, be, '0);
        expect_resp(test, '0, 1'b0, 1'b1);
      end
      "I", "T": begin
        if (req_i) idle_bus();
        drain();
        @(negedge clk_i);
        if (op == "I") begin
          check_level("ipi_o", ipi_o, exp_data[0]);
        end else begin
          check_level("timer_irq_o", timer_irq_o, exp_data[0]);
        end
      end
      "D": begin
        if (req_i) idle_bus();
        repeat (wdata) @(posedge clk_i);
      end
      // Cycle count after reset release in wdata
      "G": begin
        if (req_i) idle_bus();
        repeat (int'(wdata) - (cyc - rel_cyc)) @(posedge clk_i);
        @(negedge clk_i);
        check_level("debug_req_o", debug_req_o, exp_data[0]);
      end
      default: begin
        $display("Unknown operation %c in test %0d", op, test);
        test_errs++;
      end
    endcase
  endtask

  // -------------------------------------
  // Response checker
  // -------------------------------------
  always @(negedge clk_i) begin
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      cur = exp_q.pop_front();
      test_checks++;
      if (cur.mtime) begin
        assert (rvalid_o && !err_o && (!have_mtime || rdata_o > last_mtime)) else begin
          $display("ERR @%0t: test %0d mtime %h not above %h", $time, cur.test, rdata_o,
                   last_mtime);
          test_errs++;
        end
        last_mtime = rdata_o;
        have_mtime = 1'b1;
      end else begin
        assert (rvalid_o === !cur.err && err_o === cur.err && rdata_o === cur.data) else begin
          $display("ERR @%0t: test %0d rvalid %b err %b rdata %h, expected err %b rdata %h",
                   $time, cur.test, rvalid_o, err_o, rdata_o, cur.err, cur.data);
          test_errs++;
        end
      end
    end else begin
      assert (rvalid_o !== 1'b1 && err_o !== 1'b1) else begin
        $display("ERR @%0t: response with no request pending", $time);
        test_errs++;
      end
    end
  end

  // -------------------------------------
  // Main sequence
  // -------------------------------------
  initial begin
    int         fd;
    int         n;
    int         test;
    int         cur_test;
    int         exp_err;
    string      line;
    logic [7:0] op;
    addr_t      addr;
    be_t        be;
    data_t      wdata;
    data_t      exp_data;

    clk_i        = 1'b0;
    rtc_i        = 1'b0;
    ndmreset_n   = 1'b0;
    req_i        = 1'b0;
    we_i         = 1'b0;
    addr_i       = '0;
    be_i         = '0;
    wdata_i      = '0;
    // Held high across reset release for the hold-off check
    debug_req_i  = 1'b1;
    seed         = 32'he616;
    have_mtime   = 1'b0;
    n_lines      = 0;
    n_tests      = 0;
    test_checks  = 0;
    test_errs    = 0;
    total_checks = 0;
    total_errs   = 0;

    fd = $fopen(InputFile, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", InputFile);
      total_errs++;
    end else begin
      while ($fgets(line, fd) > 0) n_lines++;
      $fclose(fd);
      fd = $fopen(InputFile, "r");
    end

    repeat (ResetCycles) @(posedge clk_i);
    #2;
    ndmreset_n = 1'b1;
    rel_cyc    = cyc;

    cur_test = -1;
    while (fd != 0 && $fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%d %c %h %h %h %h %d", test, op, addr, be, wdata, exp_data, exp_err);
      if (n != 7) begin
        $display("Malformed stimulus line: %s", line);
        total_errs++;
        continue;
      end
      if (test != cur_test) begin
        if (cur_test >= 0) finish_test(cur_test);
        cur_test = test;
      end
      run_op(test, op, addr, be, wdata, exp_data, exp_err != 0);
    end
    if (fd != 0) $fclose(fd);
    if (cur_test >= 0) finish_test(cur_test);

    $display("tests %0d, checks %0d, errors %0d", n_tests, total_checks, total_errs);
    if (total_errs == 0 && total_checks > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial begin
    wait (n_lines > 0);
    repeat (n_lines * 10 + 2000) @(posedge clk_i);
    $display("Timeout: the run did not complete within %0d clock cycles",
             n_lines * 10 + 2000);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- logic/soc_subsystem.sv
// -------------------------------------
// SoC bus subsystem top with ROM, RAM,
// CLINT and debug hold-off
// -------------------------------------
`timescale 1ns/10ps

module soc_subsystem import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  ndmreset_n,
  input  logic  rtc_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  input  logic  debug_req_i,
  output logic  rvalid_o,
  output data_t rdata_o,
  output logic  err_o,
  output logic  timer_irq_o,
  output logic  ipi_o,
  output logic  debug_req_o
);

  logic miss;

  // One bus per target
  mem_bus_if bus [NumTargets] ();

  // -------------------------------------
  // Request side
  // -------------------------------------
  addr_decoder i_addr_decoder (
    .clk_i      ( clk_i         ),
    .ndmreset_n ( ndmreset_n    ),
    .req_i      ( req_i         ),
    .we_i       ( we_i          ),
    .addr_i     ( addr_i        ),
    .be_i       ( be_i          ),
    .wdata_i    ( wdata_i       ),
    .rom_o      ( bus[TgtRom]   ),
    .ram_o      ( bus[TgtRam]   ),
    .clint_o    ( bus[TgtClint] ),
    .miss_o     ( miss          )
  );

  // -------------------------------------
  // Targets
  // -------------------------------------
  boot_rom i_boot_rom (
    .clk_i      ( clk_i       ),
    .ndmreset_n ( ndmreset_n  ),
    .bus_i      ( bus[TgtRom] )
  );

  scratchpad_ram i_scratchpad_ram (
    .clk_i      ( clk_i       ),
    .ndmreset_n ( ndmreset_n  ),
    .bus_i      ( bus[TgtRam] )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i         ),
    .ndmreset_n  ( ndmreset_n    ),
    .rtc_i       ( rtc_i         ),
    .bus_i       ( bus[TgtClint] ),
    .timer_irq_o ( timer_irq_o   ),
    .ipi_o       ( ipi_o         )
  );

  // -------------------------------------
  // Response side
  // -------------------------------------
  resp_mux i_resp_mux (
    .clk_i      ( clk_i         ),
    .ndmreset_n ( ndmreset_n    ),
    .rom_i      ( bus[TgtRom]   ),
    .ram_i      ( bus[TgtRam]   ),
    .clint_i    ( bus[TgtClint] ),
    .miss_i     ( miss          ),
    .rvalid_o   ( rvalid_o      ),
    .rdata_o    ( rdata_o       ),
    .err_o      ( err_o         )
  );

  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- logic/resp_mux.sv
// -------------------------------------
// Response merge, registers target data,
// valid and the unmapped error
// -------------------------------------
`timescale 1ns/10ps

module resp_mux import soc_pkg::*; (
  input  logic        clk_i,
  input  logic        ndmreset_n,
  mem_bus_if.monitor  rom_i,
  mem_bus_if.monitor  ram_i,
  mem_bus_if.monitor  clint_i,
  input  logic        miss_i,
  output logic        rvalid_o,
  output data_t       rdata_o,
  output logic        err_o
);

  logic [NumTargets-1:0] valid_vec;
  data_t                 data_vec [NumTargets];
  data_t                 data_sel;
  logic                  rvalid_q;
  logic                  err_q;
  data_t                 rdata_q;

  assign valid_vec[TgtRom]   = rom_i.rvalid;
  assign valid_vec[TgtRam]   = ram_i.rvalid;
  assign valid_vec[TgtClint] = clint_i.rvalid;
  assign data_vec[TgtRom]    = rom_i.rdata;
  assign data_vec[TgtRam]    = ram_i.rdata;
  assign data_vec[TgtClint]  = clint_i.rdata;

  // AND-OR select, zero when nobody answers
  always_comb begin
    data_sel = '0;
    for (int t = 0; t < NumTargets; t++) begin
      data_sel = data_sel | (data_vec[t] & {DataWidth{valid_vec[t]}});
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= |valid_vec;
      err_q    <= miss_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= data_sel;
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

  // Decoder and targets answer each request exactly once
  a_single_resp : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0({valid_vec, miss_i}));

endmodule

//--- logic/debug_gate.sv
// -------------------------------------
// Debug request hold-off after reset
// -------------------------------------
`timescale 1ns/10ps

module debug_gate import soc_pkg::*; (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [DebugCntWidth-1:0] count_q;
  logic                     holdoff;

  // Window closes after the count reaches zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      count_q <= DebugCntWidth'(DebugHoldoffCycles);
    end else if (holdoff) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign holdoff     = |count_q;
  assign debug_req_o = debug_req_i & ~holdoff;

  // Still blocked in the last cycle of the window after release
  a_no_early_debug : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $rose(ndmreset_n) |-> ##(DebugHoldoffCycles - 1) !debug_req_o);

endmodule

//--- logic/clint_timer.sv
// -------------------------------------
// Core-local timer with mtime, mtimecmp,
// msip and an RTC divide-by-two
// -------------------------------------
`timescale 1ns/10ps

module clint_timer import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       ndmreset_n,
  input  logic       rtc_i,
  mem_bus_if.target  bus_i,
  output logic       timer_irq_o,
  output logic       ipi_o
);

  logic [1:0] rtc_sync_q;
  logic       rtc_prev_q;
  logic       rtc_div_q;
  logic       rtc_rise;
  logic       mtime_tick;
  data_t      mtime_q;
  data_t      mtime_d;
  data_t      mtimecmp_q;
  data_t      mtimecmp_d;
  logic       msip_q;
  logic       msip_d;
  logic       timer_irq_q;
  addr_t      reg_off;
  logic       wr_en;
  data_t      read_word;
  logic       rvalid_q;
  data_t      rdata_q;

  // -------------------------------------
  // RTC synchronizer and divider
  // -------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_div_q <= ~rtc_div_q;
      end
    end
  end

  assign rtc_rise   = rtc_sync_q[1] & ~rtc_prev_q;
  // Every second RTC edge
  assign mtime_tick = rtc_rise & rtc_div_q;

  // -------------------------------------
  // Register file
  // -------------------------------------
  assign reg_off = bus_i.addr << 2;
  assign wr_en   = bus_i.req & bus_i.we;

  always_comb begin
    mtime_d    = mtime_q + data_t'(mtime_tick);
    mtimecmp_d = mtimecmp_q;
    msip_d     = msip_q;
    if (wr_en && reg_off == ClintMtimecmpOff) begin
      mtimecmp_d = be_merge(mtimecmp_q, bus_i.wdata, bus_i.be);
    end
    if (wr_en && reg_off == ClintMsipOff && bus_i.be[0]) begin
      msip_d = bus_i.wdata[0];
    end
  end

  always_comb begin
    case (reg_off)
      ClintMsipOff:     read_word = {{(DataWidth-1){1'b0}}, msip_q};
      ClintMtimecmpOff: read_word = mtimecmp_q;
      ClintMtimeOff:    read_word = mtime_q;
      default:          read_word = '0;
    endcase
  end

  // Compare uses next-state values so the irq tracks a write at once
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      msip_q      <= msip_d;
      timer_irq_q <= mtime_d >= mtimecmp_d;
      rvalid_q    <= bus_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : read_word;
    end
  end

  assign bus_i.rdata  = rdata_q;
  assign bus_i.rvalid = rvalid_q;
  assign timer_irq_o  = timer_irq_q;
  assign ipi_o        = msip_q;

endmodule

//--- logic/scratchpad_ram.sv
// -------------------------------------
// Scratchpad RAM, 64 words with byte
// enable writes
// -------------------------------------
`timescale 1ns/10ps

module scratchpad_ram import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       ndmreset_n,
  mem_bus_if.target  bus_i
);

  data_t                  mem_q [RamWords];
  logic [RamIdxWidth-1:0] idx;
  logic                   wr_en;
  logic                   rvalid_q;
  data_t                  rdata_q;

  assign idx   = bus_i.addr[RamIdxWidth-1:0];
  assign wr_en = bus_i.req & bus_i.we;

  // -------------------------------------
  // Storage
  // -------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[idx] <= be_merge(mem_q[idx], bus_i.wdata, bus_i.be);
    end
  end

  // Read port, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : mem_q[idx];
    end
  end

  // -------------------------------------
  // Response strobe
  // -------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
    end
  end

  assign bus_i.rdata  = rdata_q;
  assign bus_i.rvalid = rvalid_q;

endmodule

//--- logic/boot_rom.sv
// -------------------------------------
// Boot ROM with a fixed 16-word table
// -------------------------------------
`timescale 1ns/10ps

module boot_rom import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       ndmreset_n,
  mem_bus_if.target  bus_i
);

  data_t                  rom_table [RomWords];
  logic [RomIdxWidth-1:0] idx;
  logic                   rvalid_q;
  data_t                  rdata_q;

  always_comb begin
    for (int i = 0; i < RomWords; i++) begin
      rom_table[i] = RomFillBase + data_t'(i);
    end
  end

  assign idx = bus_i.addr[RomIdxWidth-1:0];

  // Writes are acknowledged and dropped
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : rom_table[idx];
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
    end
  end

  assign bus_i.rdata  = rdata_q;
  assign bus_i.rvalid = rvalid_q;

endmodule

//--- logic/addr_decoder.sv
// -------------------------------------
// Address decoder, routes a request to one
// target and flags unmapped accesses
// -------------------------------------
`timescale 1ns/10ps

module addr_decoder import soc_pkg::*; (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic                req_i,
  input  logic                we_i,
  input  addr_t               addr_i,
  input  be_t                 be_i,
  input  data_t               wdata_i,
  mem_bus_if.initiator        rom_o,
  mem_bus_if.initiator        ram_o,
  mem_bus_if.initiator        clint_o,
  output logic                miss_o
);

  logic [NumTargets-1:0] hit;
  logic                  miss_q;

  function automatic logic in_region(addr_t addr, addr_t base, addr_t len);
    addr_t off;
    off = addr - base;
    return off < len;
  endfunction

  // Word index inside a region
  function automatic addr_t word_off(addr_t addr, addr_t base);
    return (addr - base) >> 2;
  endfunction

  // -------------------------------------
  // Rule table
  // -------------------------------------
  assign hit[TgtRom]   = in_region(addr_i, RomBase, RomLength);
  assign hit[TgtRam]   = in_region(addr_i, RamBase, RamLength);
  assign hit[TgtClint] = in_region(addr_i, ClintBase, ClintLength);

  assign rom_o.req   = req_i & hit[TgtRom];
  assign rom_o.we    = we_i;
  assign rom_o.addr  = word_off(addr_i, RomBase);
  assign rom_o.be    = be_i;
  assign rom_o.wdata = wdata_i;

  assign ram_o.req   = req_i & hit[TgtRam];
  assign ram_o.we    = we_i;
  assign ram_o.addr  = word_off(addr_i, RamBase);
  assign ram_o.be    = be_i;
  assign ram_o.wdata = wdata_i;

  assign clint_o.req   = req_i & hit[TgtClint];
  assign clint_o.we    = we_i;
  assign clint_o.addr  = word_off(addr_i, ClintBase);
  assign clint_o.be    = be_i;
  assign clint_o.wdata = wdata_i;

  // Unmapped access, answered by the merge stage as an error
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      miss_q <= 1'b0;
    end else begin
      miss_q <= req_i & ~(|hit);
    end
  end

  assign miss_o = miss_q;

  // Regions must never overlap
  a_one_target : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0({rom_o.req, ram_o.req, clint_o.req}));

endmodule

//--- logic/mem_bus_if.sv
// -------------------------------------
// Single-word strobe bus toward one target
// -------------------------------------
`timescale 1ns/10ps

interface mem_bus_if import soc_pkg::*; ();

  // Request, valid for one cycle
  logic  req;
  logic  we;
  addr_t addr;
  be_t   be;
  data_t wdata;

  // Response, one cycle after req
  data_t rdata;
  logic  rvalid;

  modport initiator (
    output req, we, addr, be, wdata,
    input  rdata, rvalid
  );

  modport target (
    input  req, we, addr, be, wdata,
    output rdata, rvalid
  );

  // Response observer for the merge stage
  modport monitor (
    input rdata, rvalid
  );

endinterface

//--- logic/soc_pkg.sv
// -------------------------------------
// Shared widths, memory map and register
// offsets of the SoC bus subsystem
// -------------------------------------
package soc_pkg;

  // -------------------------------------
  // Bus widths
  // -------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Bus targets, also used as interface array index
  typedef enum logic [1:0] {
    TgtRom,
    TgtRam,
    TgtClint
  } target_e;

  localparam int unsigned NumTargets = 3;

  // -------------------------------------
  // Memory map
  // -------------------------------------
  localparam addr_t RomBase     = 32'h0000_0000;
  localparam addr_t RomLength   = 32'h0000_0040;
  localparam addr_t RamBase     = 32'h0000_1000;
  localparam addr_t RamLength   = 32'h0000_0100;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0000_0010;

  localparam int unsigned RomWords    = 16;
  localparam int unsigned RamWords    = 64;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);
  localparam int unsigned RamIdxWidth = $clog2(RamWords);

  // Boot table pattern, word i holds this plus i
  localparam data_t RomFillBase = 32'hB007_0000;

  // CLINT byte offsets
  localparam addr_t ClintMsipOff     = 32'h0;
  localparam addr_t ClintMtimecmpOff = 32'h4;
  localparam addr_t ClintMtimeOff    = 32'h8;

  // Debug window after reset
  localparam int unsigned DebugHoldoffCycles = 20;
  localparam int unsigned DebugCntWidth      = $clog2(DebugHoldoffCycles + 1);

  // Byte lane merge of a write into an old word
  function automatic data_t be_merge(data_t old_w, data_t new_w, be_t be);
    data_t merged;
    merged = old_w;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage
